// File: Bender.yml
package:
  name: board_audio_path

export_include_dirs:
  - .

sources:
  - audio_pkg.sv
  - sample_if.sv
  - mic_capture.sv
  - sample_fifo.sv
  - i2s_audio_out.sv
  - board_specific_top.sv
  - target: simulation
    files:
      - tb_board_specific_top.sv

// File: audio_consts.svh
`ifndef AUDIO_CONSTS_SVH
`define AUDIO_CONSTS_SVH

//----------------------------------------------------------
// Microphone I2S timing

`define MIC_SCK_HALF   8     // Clk cycles per sck half period
`define MIC_SLOT_BITS  32    // Sck periods per ws half
`define MIC_DATA_BITS  24    // Valid bits from INMP441

//----------------------------------------------------------
// DAC I2S timing

`define OUT_BCLK_HALF  16    // Clk cycles per bclk half period
`define OUT_SLOT_BITS  16    // Bclk periods per lrclk half
`define MCLK_HALF      2     // Clk cycles per mclk half period

//----------------------------------------------------------
// Buffering and board widths

`define FIFO_DEPTH     4     // Entries, power of two
`define W_KEY          2
`define W_SW           2
`define W_LED          8     // Meter LEDs

`endif

// File: audio_pkg.sv
`default_nettype none

`include "audio_consts.svh"

package audio_pkg;

    //----------------------------------------------------------
    // Data types

    typedef logic signed [`MIC_DATA_BITS - 1:0] mic_word_t;  // Raw mic word
    typedef logic signed [15:0]                 sample_t;    // Processed sample
    typedef logic        [1:0]                  gain_t;      // Gain code from switches
    typedef logic        [`W_LED - 1:0]         led_bar_t;   // Thermometer bar

    // Extra MSB tells full from empty
    typedef logic [$clog2(`FIFO_DEPTH):0] fifo_ptr_t;

    //----------------------------------------------------------
    // State machines

    typedef enum logic [1:0]
    {
        MIC_IDLE,    // Wait for first left slot
        MIC_DELAY,   // One sck of I2S delay
        MIC_SHIFT,   // Data bits, MSB first
        MIC_SKIP     // Padding and right slot
    } mic_state_t;

    typedef enum logic [1:0]
    {
        OUT_LOAD,    // Silent until first frame
        OUT_DELAY,   // Delay bit period of a slot
        OUT_SHIFT    // Sample bits of a slot
    } out_state_t;

endpackage

`default_nettype wire

// File: board_specific_top.sv
`default_nettype none

`include "audio_consts.svh"

module board_specific_top
(
    input  wire                  clk,
    input  wire                  rst,

    input  wire  [`W_KEY - 1:0]  key,        // Active low, key[1] reserved
    input  wire  [`W_SW  - 1:0]  sw,         // Gain code
    output wire  [`W_LED - 1:0]  led,        // Level meter

    // INMP441 microphone
    output wire                  mic_lr,
    output wire                  mic_ws,
    output wire                  mic_sck,
    input  wire                  mic_sd,

    // I2S DAC
    output wire                  aud_mclk,
    output wire                  aud_bclk,
    output wire                  aud_lrclk,
    output wire                  aud_sdata
);

    //----------------------------------------------------------
    // Sample path

    sample_if smp_if ();

    mic_capture i_mic_capture
    (
        .clk     ( clk             ),
        .rst     ( rst             ),
        .mic_sd  ( mic_sd          ),
        .mic_sck ( mic_sck         ),
        .mic_ws  ( mic_ws          ),
        .mic_lr  ( mic_lr          ),
        .gain    ( sw              ),
        .mute    ( ~key[0]         ),   // Held key mutes
        .led     ( led             ),
        .smp     ( smp_if.producer )
    );

    sample_fifo i_sample_fifo
    (
        .clk     ( clk             ),
        .rst     ( rst             ),
        .q       ( smp_if.buffer   )
    );

    i2s_audio_out i_audio_out
    (
        .clk       ( clk             ),
        .rst       ( rst             ),
        .aud_mclk  ( aud_mclk        ),
        .aud_bclk  ( aud_bclk        ),
        .aud_lrclk ( aud_lrclk       ),
        .aud_sdata ( aud_sdata       ),
        .smp       ( smp_if.consumer )
    );

endmodule

`default_nettype wire

// File: i2s_audio_out.sv
`default_nettype none

`include "audio_consts.svh"

module i2s_audio_out
    import audio_pkg::*;
(
    input  wire         clk,
    input  wire         rst,

    output logic        aud_mclk,
    output logic        aud_bclk,
    output logic        aud_lrclk,
    output logic        aud_sdata,

    sample_if.consumer  smp
);

    localparam int mclk_cw = $clog2(`MCLK_HALF);
    localparam int bclk_cw = $clog2(`OUT_BCLK_HALF);
    localparam int slot_cw = $clog2(`OUT_SLOT_BITS);
    localparam int smp_msb = $bits(sample_t) - 1;

    logic [mclk_cw - 1:0] mclk_cnt;
    logic [bclk_cw - 1:0] bclk_cnt;
    logic [slot_cw - 1:0] slot_cnt;     // Bclk periods in current lrclk half
    logic                 bclk_tick;
    logic                 bclk_fall;
    logic                 slot_end;
    logic                 frame_start;
    out_state_t           state;
    sample_t              hold;         // Sample of current frame
    sample_t              shreg;
    sample_t              next_word;

    //----------------------------------------------------------
    // Clock generation

    assign bclk_tick   = (bclk_cnt == bclk_cw'(`OUT_BCLK_HALF - 1));
    assign bclk_fall   = bclk_tick & aud_bclk;
    assign slot_end    = bclk_fall & (slot_cnt == slot_cw'(`OUT_SLOT_BITS - 1));
    assign frame_start = slot_end & aud_lrclk;    // Lrclk about to fall

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            mclk_cnt  <= '0;
            aud_mclk  <= 1'b0;
            bclk_cnt  <= '0;
            aud_bclk  <= 1'b0;
            slot_cnt  <= '0;
            aud_lrclk <= 1'b0;
        end
        else
        begin
            if (mclk_cnt == mclk_cw'(`MCLK_HALF - 1))
            begin
                mclk_cnt <= '0;
                aud_mclk <= ~aud_mclk;
            end
            else
                mclk_cnt <= mclk_cnt + 1'b1;

            bclk_cnt <= bclk_tick ? '0 : bclk_cnt + 1'b1;
            if (bclk_tick)
                aud_bclk <= ~aud_bclk;
            if (bclk_fall)
                slot_cnt <= slot_end ? '0 : slot_cnt + 1'b1;
            if (slot_end)
                aud_lrclk <= ~aud_lrclk;   // Lrclk moves on falling bclk
        end
    end

    //----------------------------------------------------------
    // Sample fetch

    // Pop takes the head on the same edge that loads it
    assign smp.pop   = frame_start & ~smp.empty;
    assign next_word = aud_lrclk ? (smp.empty ? sample_t'(0) : smp.rdata)  // Zero on underrun
                                 : hold;                                    // Right repeats left

    always_ff @(posedge clk)
    begin
        if (bclk_fall)
        begin
            if (slot_end)
                shreg <= next_word;
            else
                shreg <= shreg << 1;
        end
        if (frame_start)
            hold <= next_word;
    end

    //----------------------------------------------------------
    // Serializer

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            state     <= OUT_LOAD;
            aud_sdata <= 1'b0;
        end
        else if (bclk_fall)
        begin
            case (state)
                OUT_LOAD:
                    if (frame_start)
                        state <= OUT_DELAY;
                OUT_DELAY:
                    state <= OUT_SHIFT;       // MSB goes out now
                OUT_SHIFT:
                    if (slot_end)
                        state <= OUT_DELAY;   // LSB lands in next delay bit
                default:
                    state <= OUT_LOAD;
            endcase
            if (state != OUT_LOAD)
                aud_sdata <= shreg[smp_msb];
        end
    end

    // DAC samples on rising bclk so data must settle while bclk is low
    a_sdata_bclk_low: assert property (@(posedge clk) disable iff (rst)
        $changed(aud_sdata) |-> !aud_bclk)
        else $error("aud_sdata changed while bclk high");

endmodule

`default_nettype wire

// File: list.f
+incdir+.
audio_pkg.sv
sample_if.sv
mic_capture.sv
sample_fifo.sv
i2s_audio_out.sv
board_specific_top.sv
tb_board_specific_top.sv

// File: mic_capture.sv
`default_nettype none

`include "audio_consts.svh"

module mic_capture
    import audio_pkg::*;
(
    input  wire               clk,
    input  wire               rst,

    input  wire               mic_sd,
    output logic              mic_sck,
    output logic              mic_ws,
    output logic              mic_lr,

    input  wire gain_t        gain,
    input  wire               mute,
    output led_bar_t          led,

    sample_if.producer        smp
);

    localparam int sck_cw     = $clog2(`MIC_SCK_HALF);
    localparam int slot_cw    = $clog2(`MIC_SLOT_BITS);
    localparam int data_cw    = $clog2(`MIC_DATA_BITS);
    localparam int mic_msb    = $bits(mic_word_t) - 1;
    localparam int smp_msb    = $bits(sample_t) - 1;
    localparam int sat_shift  = $bits(mic_word_t) - $bits(sample_t);  // Shift at gain 0
    localparam int meter_base = 7;                                    // LED 0 at 2^7

    logic [sck_cw  - 1:0] sck_cnt;
    logic [slot_cw - 1:0] slot_cnt;   // Sck periods in current ws half
    logic [data_cw - 1:0] bit_cnt;    // Bits shifted in so far
    logic                 sck_tick;
    logic                 sck_rise;
    logic                 sck_fall;
    logic                 slot_end;
    logic                 ws_q;
    logic                 ws_rise;
    logic                 frame_done;
    mic_state_t           state;
    mic_word_t            shreg;
    mic_word_t            scaled;
    sample_t              sample;
    logic [smp_msb:0]     mag;        // Unsigned magnitude
    led_bar_t             meter;

    assign mic_lr = 1'b0;             // Selects left channel

    //----------------------------------------------------------
    // Sck and ws generation

    assign sck_tick = (sck_cnt == sck_cw'(`MIC_SCK_HALF - 1));
    assign sck_rise = sck_tick & ~mic_sck;
    assign sck_fall = sck_tick &  mic_sck;
    assign slot_end = sck_fall & (slot_cnt == slot_cw'(`MIC_SLOT_BITS - 1));
    assign ws_rise  = mic_ws & ~ws_q;   // Left slot just ended

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            sck_cnt  <= '0;
            mic_sck  <= 1'b0;
            slot_cnt <= '0;
            mic_ws   <= 1'b0;
            ws_q     <= 1'b0;
        end
        else
        begin
            sck_cnt <= sck_tick ? '0 : sck_cnt + 1'b1;
            if (sck_tick)
                mic_sck <= ~mic_sck;
            if (sck_fall)
                slot_cnt <= slot_end ? '0 : slot_cnt + 1'b1;
            if (slot_end)
                mic_ws <= ~mic_ws;            // Ws moves on falling sck
            ws_q <= mic_ws;
        end
    end

    //----------------------------------------------------------
    // Left slot capture

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            state   <= MIC_IDLE;
            bit_cnt <= '0;
        end
        else
        begin
            case (state)
                MIC_IDLE, MIC_SKIP:
                    if (slot_end && mic_ws)
                        state <= MIC_DELAY;   // Ws about to fall
                MIC_DELAY:
                    if (sck_rise)
                    begin
                        state   <= MIC_SHIFT;
                        bit_cnt <= '0;
                    end
                MIC_SHIFT:
                    if (sck_rise)
                    begin
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == data_cw'(`MIC_DATA_BITS - 1))
                            state <= MIC_SKIP;  // LSB taken
                    end
                default:
                    state <= MIC_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (state == MIC_SHIFT && sck_rise)
            shreg <= {shreg[mic_msb - 1:0], mic_sd};   // MSB first
    end

    //----------------------------------------------------------
    // Gain, saturation, mute and meter

    always_comb
    begin
        scaled = shreg >>> (sat_shift - gain);
        if (&scaled[mic_msb:smp_msb] || ~|scaled[mic_msb:smp_msb])
            sample = sample_t'(scaled);                           // Fits
        else
            sample = {scaled[mic_msb], {smp_msb{~scaled[mic_msb]}}};  // Clip to rail
        if (mute)
            sample = '0;

        mag = sample[smp_msb] ? (smp_msb + 1)'(-sample) : (smp_msb + 1)'(sample);
        for (int i = 0; i < `W_LED; i++)
            meter[i] = |(mag >> (meter_base + i));  // At least 2^(7+i)
    end

    //----------------------------------------------------------
    // Push and LED update

    assign frame_done = ws_rise & (state == MIC_SKIP);  // No push before first full word

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            smp.push <= 1'b0;
            led      <= '0;
        end
        else
        begin
            smp.push <= frame_done;
            if (frame_done)
                led <= meter;
        end
    end

    always_ff @(posedge clk)
    begin
        if (frame_done)
            smp.wdata <= sample;
    end

    // Frame rates are equal so the FIFO must never be full here
    a_push_not_full: assert property (@(posedge clk) disable iff (rst)
        smp.push |-> !smp.full)
        else $error("mic_capture pushed into a full FIFO");

endmodule

`default_nettype wire

// File: sample_fifo.sv
`default_nettype none

`include "audio_consts.svh"

module sample_fifo
    import audio_pkg::*;
(
    input  wire       clk,
    input  wire       rst,

    sample_if.buffer  q
);

    localparam int aw = $clog2(`FIFO_DEPTH);   // Address width

    sample_t   mem [`FIFO_DEPTH];
    fifo_ptr_t wr_ptr;
    fifo_ptr_t rd_ptr;
    logic      do_push;
    logic      do_pop;

    //----------------------------------------------------------
    // Status

    assign q.empty = (wr_ptr == rd_ptr);
    assign q.full  = (wr_ptr[aw] != rd_ptr[aw])
                   && (wr_ptr[aw - 1:0] == rd_ptr[aw - 1:0]);  // Wrapped once

    assign do_push = q.push & ~q.full;     // Push while full is dropped
    assign do_pop  = q.pop  & ~q.empty;

    // Head of queue, valid while not empty
    assign q.rdata = mem[rd_ptr[aw - 1:0]];

    //----------------------------------------------------------
    // Pointers

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end
        else
        begin
            if (do_push)
                wr_ptr <= wr_ptr + 1'b1;
            if (do_pop)
                rd_ptr <= rd_ptr + 1'b1;
        end
    end

    //----------------------------------------------------------
    // Storage

    always_ff @(posedge clk)
    begin
        if (do_push)
            mem[wr_ptr[aw - 1:0]] <= q.wdata;
    end

    // Consumer only pops on a non-empty queue
    a_no_pop_empty: assert property (@(posedge clk) disable iff (rst)
        q.pop |-> !q.empty)
        else $error("sample_fifo popped while empty");

    a_no_push_full: assert property (@(posedge clk) disable iff (rst)
        q.push |-> !q.full)
        else $error("sample_fifo pushed while full");

endmodule

`default_nettype wire

// File: sample_if.sv
`default_nettype none

interface sample_if
    import audio_pkg::*;
();

    //----------------------------------------------------------
    // Write side

    logic    push;    // One-cycle strobe
    sample_t wdata;
    logic    full;    // Level

    //----------------------------------------------------------
    // Read side

    logic    pop;     // One-cycle strobe, takes rdata
    sample_t rdata;   // Oldest entry while not empty
    logic    empty;   // Level

    modport producer (output push, output wdata, input full);

    modport buffer
    (
        input  push, wdata, pop,
        output full, empty, rdata
    );

    modport consumer (output pop, input rdata, input empty);

endinterface

`default_nettype wire

// File: tb_board_specific_top.sv
`default_nettype none

`include "audio_consts.svh"

module tb_board_specific_top
    import audio_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_PERIOD     = 10;
    localparam int FRAME_CYCLES   = 1024;     // 2 x 32 x 16 and 2 x 16 x 32
    localparam int TIMEOUT_CYCLES = 60000;    // About 40 frames plus margin

    logic               clk     = 1'b0;
    logic               rst     = 1'b1;
    logic [`W_KEY-1:0]  key     = 2'b11;      // Released, active low
    logic [`W_SW-1:0]   sw      = 2'b00;
    logic               mic_sd  = 1'b0;
    wire  [`W_LED-1:0]  led;
    wire                mic_lr, mic_ws, mic_sck;
    wire                aud_mclk, aud_bclk, aud_lrclk, aud_sdata;

    integer             seed      = 32'hd0f2_7580;
    int                 cycle_cnt = 0;
    int                 n_errors  = 0;
    int                 n_sent    = 0;        // Left slots sent by mic model
    int                 n_matched = 0;        // Pushed samples seen at DAC
    mic_word_t          mic_q[$];             // Words waiting for a left slot
    mic_word_t          cur_word  = '0;
    logic               ws_prev   = 1'b0;
    logic               left_sent = 1'b0;
    int                 sck_idx   = 0;
    sample_t            exp_q[$];             // Expected FIFO contents
    sample_t            frame_q[$];           // Expected word per DAC frame
    bit                 frame_src[$];         // Frame carries a pushed sample
    sample_t            mon_sample;
    sample_t            dac_word;
    logic [15:0]        dac_sreg  = '0;
    logic               lr_prev   = 1'b0;
    logic               left_done = 1'b0;

    board_specific_top i_dut
    (
        .clk       ( clk       ),
        .rst       ( rst       ),
        .key       ( key       ),
        .sw        ( sw        ),
        .led       ( led       ),
        .mic_lr    ( mic_lr    ),
        .mic_ws    ( mic_ws    ),
        .mic_sck   ( mic_sck   ),
        .mic_sd    ( mic_sd    ),
        .aud_mclk  ( aud_mclk  ),
        .aud_bclk  ( aud_bclk  ),
        .aud_lrclk ( aud_lrclk ),
        .aud_sdata ( aud_sdata )
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk)
    begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT_CYCLES)
        begin
            $display("Timeout after %0d cycles, tests did not finish", cycle_cnt);
            $display("Regression failed");
            $fatal(1, "timeout");
        end
    end

    //----------------------------------------------------------
    // Reference model and checks

    function automatic sample_t expected_sample(mic_word_t w, gain_t g, logic m);
        int v;
        v = int'(w) >>> (`MIC_DATA_BITS - 16 - g);    // Drop 8 bits, minus gain
        if (m)
            return '0;
        if (v > 32767)
            v = 32767;                                // Positive rail
        else if (v < -32768)
            v = -32768;                               // Negative rail
        return sample_t'(v);
    endfunction

    function automatic led_bar_t expected_bar(sample_t s);
        int       a;
        led_bar_t bar;
        a = (s < 0) ? -int'(s) : int'(s);
        for (int i = 0; i < `W_LED; i++)
            bar[i] = (a >= (1 << (7 + i)));           // Thermometer from 2^7
        return bar;
    endfunction

    task automatic report_mismatch(input string name, input int got, input int exp);
        n_errors++;
        $display("MISMATCH at %0t ns: %s got %0d expected %0d", $time, name, got, exp);
        $display("Regression failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic expect_value(input string name, input int got, input int exp);
        assert (got == exp)
        else report_mismatch(name, got, exp);
    endtask

    //----------------------------------------------------------
    // Microphone model, one word per left slot

    always @(negedge mic_sck)
    begin
        #1;                                       // Ws settles with sck
        if (mic_ws != ws_prev)
        begin
            ws_prev = mic_ws;
            sck_idx = 0;                          // Delay bit of new slot
            if (!mic_ws)
            begin
                if (mic_q.size() > 0)
                    cur_word = mic_q.pop_front();
                else
                    cur_word = '0;                // Idle slot sends silence
                left_sent = 1'b1;
                n_sent++;
            end
        end
        else
            sck_idx++;
        if (!mic_ws && sck_idx >= 1 && sck_idx <= `MIC_DATA_BITS)
            mic_sd = cur_word[`MIC_DATA_BITS - sck_idx];   // MSB first
        else
            mic_sd = 1'b0;
    end

    // End of left slot, sample goes into the FIFO model
    always @(posedge mic_ws)
    begin
        if (left_sent)
        begin
            mon_sample = expected_sample(cur_word, sw, !key[0]);
            exp_q.push_back(mon_sample);
            @(posedge clk);
            #1;
            expect_value("led", led, expected_bar(mon_sample));
        end
    end

    //----------------------------------------------------------
    // DAC decoder

    always @(negedge aud_lrclk)
    begin
        if (!rst)
        begin
            if (exp_q.size() > 0)
            begin
                frame_q.push_back(exp_q.pop_front());
                frame_src.push_back(1'b1);
            end
            else
            begin
                frame_q.push_back('0);            // Underrun frame
                frame_src.push_back(1'b0);
            end
        end
    end

    always @(posedge aud_bclk)
    begin
        if (aud_lrclk != lr_prev)
        begin
            dac_word = {dac_sreg[14:0], aud_sdata};    // LSB is in next slot
            if (!lr_prev && frame_q.size() > 0)
            begin
                expect_value("aud_sdata left", dac_word, frame_q[0]);
                left_done = 1'b1;
            end
            else if (lr_prev && left_done)
            begin
                expect_value("aud_sdata right", dac_word, frame_q[0]);
                if (frame_src[0])
                    n_matched++;
                void'(frame_q.pop_front());
                void'(frame_src.pop_front());
                left_done = 1'b0;
            end
            lr_prev = aud_lrclk;
        end
        dac_sreg = {dac_sreg[14:0], aud_sdata};
    end

    //----------------------------------------------------------
    // Test helpers

    task automatic set_controls(input gain_t g, input logic mute_on);
        while (mic_q.size() != 0)
            @(posedge clk);
        @(negedge mic_ws);                        // Far from next ws rise
        @(posedge clk);
        #1;
        sw  = g;
        key = {1'b1, ~mute_on};
    endtask

    task automatic wait_drained();
        int target;
        while (mic_q.size() != 0)
            @(posedge clk);
        target = n_sent;
        while (n_matched < target)
            @(posedge clk);
    endtask

    task automatic check_idle_outputs();
        expect_value("mic_sck", mic_sck, 0);
        expect_value("mic_ws", mic_ws, 0);
        expect_value("mic_lr", mic_lr, 0);
        expect_value("aud_mclk", aud_mclk, 0);
        expect_value("aud_bclk", aud_bclk, 0);
        expect_value("aud_lrclk", aud_lrclk, 0);
        expect_value("aud_sdata", aud_sdata, 0);
        expect_value("led", led, 0);
    endtask

    //----------------------------------------------------------
    // Directed tests

    task automatic reset_and_periods();
        time t_ws;
        time t_lr;
        time t_mclk;
        repeat (4) @(posedge clk);
        #1;
        check_idle_outputs();                     // In the middle of reset
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;
        @(posedge clk);
        #1;
        check_idle_outputs();
        fork
            begin
                @(posedge mic_ws);
                t_ws = $time;
                @(posedge mic_ws);
                t_ws = $time - t_ws;
            end
            begin
                @(posedge aud_lrclk);
                t_lr = $time;
                @(posedge aud_lrclk);
                t_lr = $time - t_lr;
            end
            begin
                @(posedge aud_mclk);
                t_mclk = $time;
                @(posedge aud_mclk);
                t_mclk = $time - t_mclk;
            end
        join
        expect_value("mic_ws period", int'(t_ws / CLK_PERIOD), FRAME_CYCLES);
        expect_value("aud_lrclk period", int'(t_lr / CLK_PERIOD), FRAME_CYCLES);
        expect_value("aud_mclk period", int'(t_mclk / CLK_PERIOD), 2 * `MCLK_HALF);
    endtask

    task automatic passthrough_gain0();
        set_controls(2'd0, 1'b0);
        repeat (6)
            mic_q.push_back(mic_word_t'($random(seed)));
        wait_drained();
    endtask

    task automatic gain_saturation();
        int r;
        int g;
        for (g = 1; g <= 3; g++)
        begin
            set_controls(gain_t'(g), 1'b0);
            r = $random(seed);
            mic_q.push_back(24'sh7f_fff0);                     // Clips high
            mic_q.push_back(24'sh80_0010);                     // Clips low
            mic_q.push_back(mic_word_t'($signed(r[19:0])));    // Fits at any gain
        end
        wait_drained();
    endtask

    task automatic mute_release();
        set_controls(2'd1, 1'b1);                 // Key 0 held
        repeat (3)
            mic_q.push_back(mic_word_t'($random(seed)));
        set_controls(2'd1, 1'b0);
        repeat (3)
            mic_q.push_back(mic_word_t'($random(seed)));
        wait_drained();
    endtask

    task automatic level_meter();
        int mag;
        int i;
        set_controls(2'd3, 1'b0);                 // Sample is word / 32
        for (i = 0; i < `W_LED; i++)
        begin
            mag = (1 << (7 + i)) - (i % 2);       // Odd steps just below threshold
            if (i % 3 == 1)
                mag = -mag;
            mic_q.push_back(mic_word_t'(mag <<< 5));
        end
        wait_drained();
    endtask

    initial
    begin
        reset_and_periods();
        passthrough_gain0();
        gain_saturation();
        mute_release();
        level_meter();
        if (n_errors == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

endmodule

`default_nettype wire
